// ==== hdl/cent_io_pkg.sv ====
// ********************
// shared types for the cpu i/o block
// bus widths, region decode constants,
// earom control bits, trackball and panel widths
// ********************
package cent_io_pkg;

	// cpu bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// address bits 13..10 pick a 1k region of the i/o page
	typedef logic [3:0] io_region_t;

	localparam io_region_t REGION_SWITCH   = 4'h2;
	localparam io_region_t REGION_INPUT    = 4'h3;
	// earom sits in the upper half, a9 set
	localparam io_region_t REGION_EAROM    = 4'h5;
	localparam io_region_t REGION_OUT0     = 4'h7;
	localparam io_region_t REGION_STEERCLR = 4'h9;

	// earom sub function, address bits 8..7
	typedef logic [1:0] ea_sub_t;

	localparam ea_sub_t EA_SUB_ADDR = 2'd0;
	localparam ea_sub_t EA_SUB_CTRL = 2'd1;
	localparam ea_sub_t EA_SUB_READ = 2'd2;

	// score store and control register
	typedef logic [5:0] earom_addr_t;
	typedef logic [3:0] earom_ctrl_t;

	localparam int EA_BIT_CS    = 3;
	localparam int EA_BIT_ERASE = 2;
	localparam int EA_BIT_WE_N  = 1;
	// deselected, write enable off
	localparam earom_ctrl_t EAROM_CTRL_RESET = 4'b0010;

	// read source, registered one cycle behind the strobe
	typedef logic [2:0] rd_sel_t;

	localparam rd_sel_t RD_IDLE   = 3'd0;
	localparam rd_sel_t RD_NONE   = 3'd1;
	localparam rd_sel_t RD_SWITCH = 3'd2;
	localparam rd_sel_t RD_INPUT  = 3'd3;
	localparam rd_sel_t RD_EAROM  = 3'd4;

	// panel side
	typedef logic [3:0] trak_count_t;
	typedef logic [9:0] player_in_t;
	typedef logic [7:0] trakball_raw_t;
	typedef logic [3:0] led_t;
	typedef logic [2:0] coin_ctr_t;

endpackage

// ==== hdl/io_addr_decode.sv ====
// ********************
// i/o page address decoder
// write strobes for out0, steer clear, earom
// registered read source select
// ********************
`timescale 1ns/100ps

module io_addr_decode (
	input  logic                   s_6mhz,
	input  logic                   reset,
	input  cent_io_pkg::cpu_addr_t addr_i,
	input  logic                   wr_i,
	input  logic                   rd_i,
	output logic                   out0_wr_o,
	output logic                   steer_clr_o,
	output logic                   ea_addr_wr_o,
	output logic                   ea_ctrl_wr_o,
	output cent_io_pkg::rd_sel_t   rd_sel_o,
	output logic [1:0]             rd_lo_o
);
	import cent_io_pkg::*;

	io_region_t region;
	ea_sub_t    ea_sub;
	logic       ea_page;
	rd_sel_t    rd_src;

	// a15..a14 not decoded, same as the board
	assign region = addr_i[13:10];
	assign ea_sub = addr_i[8:7];

	// earom only in the a9 half of its region
	assign ea_page = (region == REGION_EAROM) && addr_i[9];

	// write strobes, single cycle like wr_i
	assign out0_wr_o    = wr_i && (region == REGION_OUT0);
	assign steer_clr_o  = wr_i && (region == REGION_STEERCLR);
	assign ea_addr_wr_o = wr_i && ea_page && (ea_sub == EA_SUB_ADDR);
	assign ea_ctrl_wr_o = wr_i && ea_page && (ea_sub == EA_SUB_CTRL);

	// source of a read at this address
	always_comb
	begin
		if (region == REGION_SWITCH)
			rd_src = RD_SWITCH;
		else if (region == REGION_INPUT)
			rd_src = RD_INPUT;
		else if (ea_page && (ea_sub == EA_SUB_READ))
			rd_src = RD_EAROM;
		else
			rd_src = RD_NONE;
	end

	// idle unless a read was strobed last cycle
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			rd_sel_o <= RD_IDLE;
		else if (rd_i)
			rd_sel_o <= rd_src;
		else
			rd_sel_o <= RD_IDLE;
	end

	// low address bits pick the byte inside a region
	always_ff @(posedge s_6mhz)
	begin
		if (rd_i)
			rd_lo_o <= addr_i[1:0];
	end

endmodule

// ==== hdl/output_latch.sv ====
// ********************
// eight bit addressable output latch
// flip, four leds, three coin counters
// ********************
`timescale 1ns/100ps

module output_latch (
	input  logic                   s_6mhz,
	input  logic                   reset,
	input  logic                   out0_wr_i,
	input  logic [2:0]             bit_sel_i,
	input  logic                   bit_val_i,
	output logic                   flip_o,
	output cent_io_pkg::led_t      led_o,
	output cent_io_pkg::coin_ctr_t coin_ctr_o
);

	logic [7:0] out_bits;

	// one bit per write, address picks the bit, d7 is the value
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			out_bits <= '0;
		else if (out0_wr_i)
			out_bits[bit_sel_i] <= bit_val_i;
	end

	// bit 7 flips the screen and picks the player 1 trackball
	assign flip_o = out_bits[7];

	// leds 4..1 on bits 6..3
	assign led_o = out_bits[6:3];

	// coin counters right, centre, left
	assign coin_ctr_o = out_bits[2:0];

endmodule

// ==== hdl/trakball_counter.sv ====
// ********************
// mini trak ball inputs
// player select by flip, two stage sync
// edge detect and up/down counters per axis
// ********************
`timescale 1ns/100ps

module trakball_counter (
	input  logic                       s_6mhz,
	input  logic                       reset,
	input  cent_io_pkg::trakball_raw_t trakball_i,
	input  logic                       flip_i,
	input  logic                       steer_clr_i,
	output cent_io_pkg::trak_count_t   tra_o,
	output cent_io_pkg::trak_count_t   trb_o,
	output logic                       dir1_o,
	output logic                       dir2_o
);
	import cent_io_pkg::*;

	// selected lines, order h dir, h ck, v dir, v ck
	logic [3:0]  tb_sel;
	logic [3:0]  tb_s1;
	logic [3:0]  tb_s2;
	// per axis, index 0 horizontal, 1 vertical
	logic [1:0]  ck;
	logic [1:0]  dir;
	logic [1:0]  ck_q;
	logic [1:0]  rise;
	logic [1:0]  dir_q;
	trak_count_t cnt [0:1];

	// raw bits alternate player 1 / player 2
	// flip set means player 1 is at the controls
	assign tb_sel = flip_i ?
		{trakball_i[7], trakball_i[5], trakball_i[3], trakball_i[1]} :
		{trakball_i[6], trakball_i[4], trakball_i[2], trakball_i[0]};

	// trackball lines are asynchronous to the board clock
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			tb_s1 <= '0;
			tb_s2 <= '0;
		end
		else
		begin
			tb_s1 <= tb_sel;
			tb_s2 <= tb_s1;
		end
	end

	assign ck   = {tb_s2[0], tb_s2[2]};
	assign dir  = {tb_s2[1], tb_s2[3]};
	assign rise = ck & ~ck_q;

	// count on the rising edge of each axis clock
	// direction sampled on that same edge
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
		begin
			ck_q   <= '0;
			dir_q  <= '0;
			cnt[0] <= '0;
			cnt[1] <= '0;
		end
		else
		begin
			ck_q <= ck;
			for (int i = 0; i < 2; i++)
			begin
				if (rise[i])
					dir_q[i] <= dir[i];
				// steer clear wins over a pulse in the same cycle
				if (steer_clr_i)
					cnt[i] <= '0;
				else if (rise[i])
					cnt[i] <= dir[i] ? cnt[i] + 4'd1 : cnt[i] - 4'd1;
			end
		end
	end

	// wraps mod 16, the game only looks at deltas
	assign tra_o  = cnt[0];
	assign trb_o  = cnt[1];
	assign dir1_o = dir_q[0];
	assign dir2_o = dir_q[1];

endmodule

// ==== hdl/earom_ctrl.sv ====
// ********************
// high score earom
// address/data latch and control register
// 64 x 8 store with a second hiscore port
// ********************
`timescale 1ns/100ps

module earom_ctrl (
	input  logic                     s_6mhz,
	input  logic                     reset,
	input  logic                     addr_wr_i,
	input  logic                     ctrl_wr_i,
	input  cent_io_pkg::earom_addr_t addr_lo_i,
	input  cent_io_pkg::cpu_data_t   wdata_i,
	input  cent_io_pkg::earom_addr_t hs_addr_i,
	input  cent_io_pkg::cpu_data_t   hs_wdata_i,
	input  logic                     hs_wr_i,
	output cent_io_pkg::cpu_data_t   ea_rdata_o,
	output cent_io_pkg::cpu_data_t   hs_rdata_o
);
	import cent_io_pkg::*;

	earom_addr_t ea_addr;
	cpu_data_t   ea_wdata;
	earom_ctrl_t ea_ctrl;
	logic        ea_sel;
	logic        ea_we;
	cpu_data_t   ea_din;
	cpu_data_t   store [0:63];

	// cpu writes address and data in one access
	// a5..a0 is the cell, the data bus is the byte
	always_ff @(posedge s_6mhz)
	begin
		if (addr_wr_i)
		begin
			ea_addr  <= addr_lo_i;
			ea_wdata <= wdata_i;
		end
	end

	// control register
	// d3 chip select, d2 erase, d1 stored inverted, d0 kept as written
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			ea_ctrl <= EAROM_CTRL_RESET;
		else if (ctrl_wr_i)
			ea_ctrl <= {wdata_i[3:2], ~wdata_i[1], wdata_i[0]};
	end

	assign ea_sel = ea_ctrl[EA_BIT_CS];
	assign ea_we  = ~ea_ctrl[EA_BIT_WE_N];

	// erase writes an all zero byte
	assign ea_din = ea_ctrl[EA_BIT_ERASE] ? 8'h00 : ea_wdata;

	// store runs every cycle while selected
	// cpu side either writes the latch or reads the latched cell
	// hiscore side is free running, its write lands last
	always_ff @(posedge s_6mhz)
	begin
		if (ea_sel)
		begin
			if (ea_we)
				store[ea_addr] <= ea_din;
			else
				ea_rdata_o <= store[ea_addr];
		end
		if (hs_wr_i)
			store[hs_addr_i] <= hs_wdata_i;
		hs_rdata_o <= store[hs_addr_i];
	end

endmodule

// ==== hdl/io_read_mux.sv ====
// ********************
// cpu read data multiplexer
// option switches, player inputs, joystick,
// trackball counts and earom byte
// ********************
`timescale 1ns/100ps

module io_read_mux (
	input  logic                     s_6mhz,
	input  logic                     reset,
	input  cent_io_pkg::rd_sel_t     rd_sel_i,
	input  logic [1:0]               rd_lo_i,
	input  cent_io_pkg::cpu_data_t   sw1_i,
	input  cent_io_pkg::cpu_data_t   sw2_i,
	input  cent_io_pkg::player_in_t  player_i,
	input  cent_io_pkg::cpu_data_t   joystick_i,
	input  logic                     vblank_i,
	input  cent_io_pkg::trak_count_t tra_i,
	input  cent_io_pkg::trak_count_t trb_i,
	input  logic                     dir1_i,
	input  logic                     dir2_i,
	input  cent_io_pkg::cpu_data_t   ea_rdata_i,
	output cent_io_pkg::cpu_data_t   rdata_o,
	output logic                     rvalid_o
);
	import cent_io_pkg::*;

	cpu_data_t in0_byte;
	cpu_data_t in1_byte;
	cpu_data_t sel_byte;
	cpu_data_t held_byte;
	logic      rd_active;

	// in0, a0 low is the horizontal ball plus status
	// a0 high is coins, slam, fire and start
	assign in0_byte = rd_lo_i[0] ?
		{player_i[9:7], player_i[4], player_i[1:0], player_i[3:2]} :
		{dir1_i, vblank_i, player_i[6], player_i[5], tra_i};

	// in1, vertical ball or both joysticks
	assign in1_byte = rd_lo_i[0] ? joystick_i : {dir2_i, 3'b000, trb_i};

	always_comb
	begin
		case (rd_sel_i)
			RD_SWITCH: sel_byte = rd_lo_i[0] ? sw2_i : sw1_i;
			RD_INPUT:  sel_byte = rd_lo_i[1] ? in1_byte : in0_byte;
			RD_EAROM:  sel_byte = ea_rdata_i;
			// unmapped addresses read as zero
			default:   sel_byte = 8'h00;
		endcase
	end

	// select is already one cycle behind rd_i
	assign rd_active = (rd_sel_i != RD_IDLE);

	// keep the last answer on the bus between reads
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			held_byte <= '0;
		else if (rd_active)
			held_byte <= sel_byte;
	end

	assign rvalid_o = rd_active;
	assign rdata_o  = rd_active ? sel_byte : held_byte;

endmodule

// ==== hdl/cent_io_top.sv ====
// ********************
// cpu side i/o block of the board
// decoder, output latch, trackball,
// earom and read multiplexer
// ********************
`timescale 1ns/100ps

module cent_io_top (
	input  logic                       s_6mhz,
	input  logic                       reset,
	input  cent_io_pkg::cpu_addr_t     addr_i,
	input  cent_io_pkg::cpu_data_t     wdata_i,
	input  logic                       wr_i,
	input  logic                       rd_i,
	input  cent_io_pkg::cpu_data_t     sw1_i,
	input  cent_io_pkg::cpu_data_t     sw2_i,
	input  cent_io_pkg::player_in_t    player_i,
	input  cent_io_pkg::cpu_data_t     joystick_i,
	input  cent_io_pkg::trakball_raw_t trakball_i,
	input  logic                       vblank_i,
	input  cent_io_pkg::earom_addr_t   hs_addr_i,
	input  cent_io_pkg::cpu_data_t     hs_wdata_i,
	input  logic                       hs_wr_i,
	output cent_io_pkg::cpu_data_t     rdata_o,
	output logic                       rvalid_o,
	output logic                       flip_o,
	output cent_io_pkg::led_t          led_o,
	output cent_io_pkg::coin_ctr_t     coin_ctr_o,
	output cent_io_pkg::cpu_data_t     hs_rdata_o
);
	import cent_io_pkg::*;

	// decoder strobes
	logic        out0_wr;
	logic        steer_clr;
	logic        ea_addr_wr;
	logic        ea_ctrl_wr;
	rd_sel_t     rd_sel;
	logic [1:0]  rd_lo;
	// panel state
	logic        flip;
	trak_count_t tra;
	trak_count_t trb;
	logic        dir1;
	logic        dir2;
	cpu_data_t   ea_rdata;

	io_addr_decode i_decode (
		.s_6mhz       (s_6mhz),
		.reset        (reset),
		.addr_i       (addr_i),
		.wr_i         (wr_i),
		.rd_i         (rd_i),
		.out0_wr_o    (out0_wr),
		.steer_clr_o  (steer_clr),
		.ea_addr_wr_o (ea_addr_wr),
		.ea_ctrl_wr_o (ea_ctrl_wr),
		.rd_sel_o     (rd_sel),
		.rd_lo_o      (rd_lo)
	);

	// a2..a0 picks the latch bit, d7 the value
	output_latch i_out0 (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.out0_wr_i  (out0_wr),
		.bit_sel_i  (addr_i[2:0]),
		.bit_val_i  (wdata_i[7]),
		.flip_o     (flip),
		.led_o      (led_o),
		.coin_ctr_o (coin_ctr_o)
	);

	// flip also selects which player's ball is counted
	trakball_counter i_trak (
		.s_6mhz      (s_6mhz),
		.reset       (reset),
		.trakball_i  (trakball_i),
		.flip_i      (flip),
		.steer_clr_i (steer_clr),
		.tra_o       (tra),
		.trb_o       (trb),
		.dir1_o      (dir1),
		.dir2_o      (dir2)
	);

	earom_ctrl i_earom (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.addr_wr_i  (ea_addr_wr),
		.ctrl_wr_i  (ea_ctrl_wr),
		.addr_lo_i  (addr_i[5:0]),
		.wdata_i    (wdata_i),
		.hs_addr_i  (hs_addr_i),
		.hs_wdata_i (hs_wdata_i),
		.hs_wr_i    (hs_wr_i),
		.ea_rdata_o (ea_rdata),
		.hs_rdata_o (hs_rdata_o)
	);

	io_read_mux i_rdmux (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.rd_sel_i   (rd_sel),
		.rd_lo_i    (rd_lo),
		.sw1_i      (sw1_i),
		.sw2_i      (sw2_i),
		.player_i   (player_i),
		.joystick_i (joystick_i),
		.vblank_i   (vblank_i),
		.tra_i      (tra),
		.trb_i      (trb),
		.dir1_i     (dir1),
		.dir2_i     (dir2),
		.ea_rdata_i (ea_rdata),
		.rdata_o    (rdata_o),
		.rvalid_o   (rvalid_o)
	);

	assign flip_o = flip;

endmodule

// ==== bench/cent_io_properties.sv ====
// ********************
// bound assertions on the i/o block
// read handshake, bus strobes,
// coin counters before the first out0 write
// ********************
`timescale 1ns/100ps

module cent_io_properties (
	input logic                   s_6mhz,
	input logic                   reset,
	input cent_io_pkg::cpu_addr_t addr_i,
	input logic                   wr_i,
	input logic                   rd_i,
	input logic                   rvalid_i,
	input cent_io_pkg::coin_ctr_t coin_ctr_i
);
	import cent_io_pkg::*;

	logic out0_seen;
	// failed assertions, read by the testbench at the end
	int   fail_count = 0;

	// set by the first write into the out0 region
	always_ff @(posedge s_6mhz or posedge reset)
	begin
		if (reset)
			out0_seen <= 1'b0;
		else if (wr_i && (addr_i[13:10] == REGION_OUT0))
			out0_seen <= 1'b1;
	end

	// rvalid is exactly one cycle behind rd
	a_rvalid_after_rd: assert property (@(posedge s_6mhz) disable iff (reset)
		rd_i |=> rvalid_i)
	else
	begin
		$error("rvalid_o missing one cycle after rd_i");
		fail_count++;
	end

	a_rvalid_only_after_rd: assert property (@(posedge s_6mhz) disable iff (reset)
		rvalid_i |-> $past(rd_i))
	else
	begin
		$error("rvalid_o without rd_i one cycle earlier");
		fail_count++;
	end

	// one strobe per cycle at most
	a_no_rd_wr: assert property (@(posedge s_6mhz) disable iff (reset)
		!(wr_i && rd_i))
	else
	begin
		$error("wr_i and rd_i high in the same cycle");
		fail_count++;
	end

	// coin counters stay quiet until software touches out0
	a_coin_idle: assert property (@(posedge s_6mhz) disable iff (reset)
		!out0_seen |-> (coin_ctr_i == '0))
	else
	begin
		$error("coin_ctr_o active before any out0 write");
		fail_count++;
	end

endmodule

// ==== bench/tb_cent_io.sv ====
// ********************
// testbench for the cpu i/o block
// clock, reset, lfsr, bus tasks
// compare tasks, directed tests for
// reads, out0 latch, trackball, earom
// ********************
`timescale 1ns/100ps

module tb_cent_io;
	import cent_io_pkg::*;

	logic          s_6mhz;
	logic          reset;
	cpu_addr_t     addr;
	cpu_data_t     wdata;
	logic          wr;
	logic          rd;
	cpu_data_t     sw1;
	cpu_data_t     sw2;
	player_in_t    player;
	cpu_data_t     joystick;
	trakball_raw_t trakball;
	logic          vblank;
	earom_addr_t   hs_addr;
	cpu_data_t     hs_wdata;
	logic          hs_wr;
	cpu_data_t     rdata;
	logic          rvalid;
	logic          flip;
	led_t          led;
	coin_ctr_t     coin_ctr;
	cpu_data_t     hs_rdata;

	// reference state
	logic [31:0]   lfsr;
	cpu_data_t     latch_m;
	trak_count_t   tra_m;
	trak_count_t   trb_m;
	logic          dir1_m;
	logic          dir2_m;
	cpu_data_t     earom_m [0:63];
	int            mismatch_count;
	int            timeout_count;

	cent_io_top i_dut (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.addr_i     (addr),
		.wdata_i    (wdata),
		.wr_i       (wr),
		.rd_i       (rd),
		.sw1_i      (sw1),
		.sw2_i      (sw2),
		.player_i   (player),
		.joystick_i (joystick),
		.trakball_i (trakball),
		.vblank_i   (vblank),
		.hs_addr_i  (hs_addr),
		.hs_wdata_i (hs_wdata),
		.hs_wr_i    (hs_wr),
		.rdata_o    (rdata),
		.rvalid_o   (rvalid),
		.flip_o     (flip),
		.led_o      (led),
		.coin_ctr_o (coin_ctr),
		.hs_rdata_o (hs_rdata)
	);

	bind cent_io_top cent_io_properties i_props (
		.s_6mhz     (s_6mhz),
		.reset      (reset),
		.addr_i     (addr_i),
		.wr_i       (wr_i),
		.rd_i       (rd_i),
		.rvalid_i   (rvalid_o),
		.coin_ctr_i (coin_ctr_o)
	);

	// 25 MHz stand-in, 40 ns period
	initial
	begin
		s_6mhz = 1'b0;
		forever
			#20 s_6mhz = ~s_6mhz;
	end

	// fibonacci lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			// taps 32 22 2 1
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	// i/o page address, a15..a14 left at zero
	function automatic cpu_addr_t region_addr(input io_region_t r, input logic [9:0] lo);
		return {2'b00, r, lo};
	endfunction

	// earom half of the region has a9 set, a8..a7 pick the sub function
	function automatic cpu_addr_t ea_addr(input ea_sub_t sub, input earom_addr_t a);
		return region_addr(REGION_EAROM, {1'b1, sub, 1'b0, a});
	endfunction

	task automatic check_data(input string name, input cpu_data_t exp, input cpu_data_t got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_trak(input string name, input trak_count_t exp, input trak_count_t got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_led(input string name, input led_t exp, input led_t got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_coin(input string name, input coin_ctr_t exp, input coin_ctr_t got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("MISMATCH %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = i_dut.i_props.fail_count;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, assert_fails);
		if (mismatch_count == 0 && timeout_count == 0 && assert_fails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	task automatic bus_write(input cpu_addr_t a, input cpu_data_t d);
		@(posedge s_6mhz);
		addr  <= a;
		wdata <= d;
		wr    <= 1'b1;
		@(posedge s_6mhz);
		wr <= 1'b0;
	endtask

	task automatic bus_read(input cpu_addr_t a, output cpu_data_t d);
		int waited;
		@(posedge s_6mhz);
		addr <= a;
		rd   <= 1'b1;
		@(posedge s_6mhz);
		rd <= 1'b0;
		waited = 0;
		@(negedge s_6mhz);
		while (!rvalid && waited < 8)
		begin
			@(negedge s_6mhz);
			waited++;
		end
		if (!rvalid)
		begin
			timeout_count++;
			$display("read at %h timed out, rvalid_o never came", a);
		end
		else
			d = rdata;
	endtask

	task automatic check_outputs();
		@(negedge s_6mhz);
		check_flag("flip_o", latch_m[7], flip);
		check_led("led_o", latch_m[6:3], led);
		check_coin("coin_ctr_o", latch_m[2:0], coin_ctr);
	endtask

	// d7 carries the bit value, the rest of the byte is noise
	task automatic latch_write(input int b, input logic v);
		cpu_data_t d;
		d       = cpu_data_t'(rand_bits(8));
		d[7]    = v;
		latch_m[b] = v;
		bus_write(region_addr(REGION_OUT0, {7'd0, b[2:0]}), d);
		check_outputs();
	endtask

	// player 1 on odd lines, player 2 on even
	// per player from the low bit: v ck, v dir, h ck, h dir
	task automatic trak_pulses(input logic p1, input logic vert, input logic up,
		input int n, input logic counted);
		int ck_bit;
		int dir_bit;
		ck_bit  = (vert ? 0 : 4) + int'(p1);
		dir_bit = ck_bit + 2;
		@(posedge s_6mhz);
		trakball[dir_bit] <= up;
		for (int i = 0; i < n; i++)
		begin
			repeat (4) @(posedge s_6mhz);
			trakball[ck_bit] <= 1'b1;
			repeat (4) @(posedge s_6mhz);
			trakball[ck_bit] <= 1'b0;
		end
		// last edge still in the synchronizer
		repeat (6) @(posedge s_6mhz);
		if (counted && vert)
		begin
			dir2_m = up;
			trb_m  = up ? trb_m + trak_count_t'(n) : trb_m - trak_count_t'(n);
		end
		else if (counted)
		begin
			dir1_m = up;
			tra_m  = up ? tra_m + trak_count_t'(n) : tra_m - trak_count_t'(n);
		end
	endtask

	// in0 and in1 with a0 low carry the ball counts
	task automatic check_trak_reads();
		cpu_data_t got;
		bus_read(region_addr(REGION_INPUT, 10'd0), got);
		check_trak("tra", tra_m, got[3:0]);
		check_data("rdata_o in0", {dir1_m, vblank, player[6], player[5], tra_m}, got);
		bus_read(region_addr(REGION_INPUT, 10'd2), got);
		check_trak("trb", trb_m, got[3:0]);
		check_data("rdata_o in1", {dir2_m, 3'b000, trb_m}, got);
	endtask

	task automatic test_switch_reads();
		cpu_data_t   got;
		logic [31:0] r;
		repeat (4)
		begin
			r = rand_bits(1);
			@(posedge s_6mhz);
			sw1      <= cpu_data_t'(rand_bits(8));
			sw2      <= cpu_data_t'(rand_bits(8));
			player   <= player_in_t'(rand_bits(10));
			joystick <= cpu_data_t'(rand_bits(8));
			vblank   <= r[0];
			bus_read(region_addr(REGION_SWITCH, 10'd0), got);
			check_data("rdata_o sw1", sw1, got);
			bus_read(region_addr(REGION_SWITCH, 10'd1), got);
			check_data("rdata_o sw2", sw2, got);
			// coins r c l, slam, fire2 fire1, start2 start1
			bus_read(region_addr(REGION_INPUT, 10'd1), got);
			check_data("rdata_o in0 hi", {player[9:7], player[4], player[1:0], player[3:2]},
				got);
			bus_read(region_addr(REGION_INPUT, 10'd3), got);
			check_data("rdata_o joystick", joystick, got);
			check_trak_reads();
			// unmapped region reads zero
			bus_read(region_addr(4'hC, 10'd0), got);
			check_data("rdata_o unmapped", 8'h00, got);
		end
	endtask

	task automatic test_output_latch();
		for (int b = 0; b < 8; b++)
			latch_write(b, 1'b1);
		for (int b = 0; b < 8; b++)
			latch_write(b, 1'b0);
	endtask

	task automatic test_trackball();
		// flip clear, player 2 counted
		trak_pulses(1'b0, 1'b0, 1'b1, 5, 1'b1);
		trak_pulses(1'b0, 1'b1, 1'b0, 3, 1'b1);
		check_trak_reads();
		// flip set, player 1 takes over
		latch_write(7, 1'b1);
		trak_pulses(1'b1, 1'b0, 1'b0, 7, 1'b1);
		trak_pulses(1'b1, 1'b1, 1'b1, 20, 1'b1);
		// player 2 ball ignored now
		trak_pulses(1'b0, 1'b0, 1'b1, 2, 1'b0);
		check_trak_reads();
	endtask

	task automatic test_steer_clear();
		bus_write(region_addr(REGION_STEERCLR, 10'd0), cpu_data_t'(rand_bits(8)));
		tra_m = '0;
		trb_m = '0;
		check_trak_reads();
	endtask

	// latch the cell in read mode, then read it through the earom port
	task automatic ea_cpu_read(input earom_addr_t a, output cpu_data_t d);
		bus_write(ea_addr(EA_SUB_ADDR, a), cpu_data_t'(rand_bits(8)));
		bus_read(ea_addr(EA_SUB_READ, 6'd0), d);
	endtask

	task automatic hs_write(input earom_addr_t a, input cpu_data_t d);
		@(posedge s_6mhz);
		hs_addr  <= a;
		hs_wdata <= d;
		hs_wr    <= 1'b1;
		@(posedge s_6mhz);
		hs_wr <= 1'b0;
	endtask

	task automatic hs_read(input earom_addr_t a, output cpu_data_t d);
		@(posedge s_6mhz);
		hs_addr <= a;
		// one cycle latency on the hiscore port
		@(posedge s_6mhz);
		@(negedge s_6mhz);
		d = hs_rdata;
	endtask

	task automatic test_earom();
		earom_addr_t cells [0:3];
		cpu_data_t   got;
		cpu_data_t   d;
		cells[0] = 6'h00;
		cells[1] = 6'h15;
		cells[2] = 6'h2a;
		cells[3] = 6'h3f;
		// selected, write enabled
		bus_write(ea_addr(EA_SUB_CTRL, 6'd0), 8'h0A);
		for (int i = 0; i < 4; i++)
		begin
			d = cpu_data_t'(rand_bits(8));
			bus_write(ea_addr(EA_SUB_ADDR, cells[i]), d);
			earom_m[cells[i]] = d;
		end
		// selected, read
		bus_write(ea_addr(EA_SUB_CTRL, 6'd0), 8'h08);
		for (int i = 0; i < 4; i++)
		begin
			ea_cpu_read(cells[i], got);
			check_data("rdata_o earom", earom_m[cells[i]], got);
		end
		// erase one cell
		bus_write(ea_addr(EA_SUB_ADDR, cells[1]), 8'hff);
		bus_write(ea_addr(EA_SUB_CTRL, 6'd0), 8'h0E);
		bus_write(ea_addr(EA_SUB_CTRL, 6'd0), 8'h08);
		earom_m[cells[1]] = 8'h00;
		ea_cpu_read(cells[1], got);
		check_data("rdata_o erased", 8'h00, got);
		for (int i = 0; i < 4; i++)
		begin
			hs_read(cells[i], got);
			check_data("hs_rdata_o", earom_m[cells[i]], got);
		end
		// hiscore side write, cpu side read
		d = cpu_data_t'(rand_bits(8));
		hs_write(6'h21, d);
		earom_m[6'h21] = d;
		ea_cpu_read(6'h21, got);
		check_data("rdata_o from hs", earom_m[6'h21], got);
	endtask

	initial
	begin
		lfsr           = 32'hb8797ea0;
		mismatch_count = 0;
		timeout_count  = 0;
		latch_m        = '0;
		tra_m          = '0;
		trb_m          = '0;
		dir1_m         = 1'b0;
		dir2_m         = 1'b0;
		reset          = 1'b1;
		addr           = '0;
		wdata          = '0;
		wr             = 1'b0;
		rd             = 1'b0;
		sw1            = '0;
		sw2            = '0;
		player         = '0;
		joystick       = '0;
		trakball       = '0;
		vblank         = 1'b0;
		hs_addr        = '0;
		hs_wdata       = '0;
		hs_wr          = 1'b0;
		repeat (16) @(posedge s_6mhz);
		reset <= 1'b0;
		check_outputs();
		test_switch_reads();
		test_output_latch();
		test_trackball();
		test_steer_clear();
		test_earom();
		finish_run();
	end

endmodule

// ==== tb.f ====
hdl/cent_io_pkg.sv
hdl/io_addr_decode.sv
hdl/output_latch.sv
hdl/trakball_counter.sv
hdl/earom_ctrl.sv
hdl/io_read_mux.sv
hdl/cent_io_top.sv
bench/cent_io_properties.sv
bench/tb_cent_io.sv
